// ==== Bender.yml ====
package:
  name: regblk

sources:
  - hdl/regblk_pkg.sv
  - hdl/regblk_bus_if.sv
  - hdl/apb_frontend.sv
  - hdl/control_regs.sv
  - hdl/status_regs.sv
  - hdl/regblk_top.sv
  - target: test
    files:
      - testbench/tb_regblk.sv

// ==== regblk.f ====
hdl/regblk_pkg.sv
hdl/regblk_bus_if.sv
hdl/apb_frontend.sv
hdl/control_regs.sv
hdl/status_regs.sv
hdl/regblk_top.sv
testbench/tb_regblk.sv

// ==== testbench/tb_regblk_golden.txt ====
# op    addr  data      strb  rdata     slverr  side
# side digits are trigger, irq, status, irq_en, mode
idle    0000  00000004  0     -         -       00000
read    1000  00000000  0     00000000  0       00000
write   1000  a5a5a5a5  1     -         0       000a5
write   1000  12345678  c     -         0       000a5
write   1000  ffffff3c  2     -         0       000a5
read    1000  00000000  0     1234ffa5  0       000a5
write   1000  00000031  1     -         0       00031
write   1004  0000000b  f     -         0       b0031
write   1004  00000006  e     -         0       00031
read    1004  00000000  0     00000000  0       00031
set     0000  00000004  0     -         -       00431
set     0000  00000001  0     -         -       01531
set     0000  00000000  0     -         -       01531
read    1008  00000000  0     00000005  0       01531
write   1008  00000004  f     -         0       01131
set     0000  00000001  0     -         -       01131
write   1008  00000001  f     -         0       01131
set     0000  00000000  0     -         -       01131
write   1008  00000001  f     -         0       00031
set     0000  00000008  0     -         -       00831
set     0000  00000000  0     -         -       00831
write   1000  00000081  1     -         0       01881
read    100c  00000000  0     sampled   0       01881
idle    0000  00000003  0     -         -       01881
write   100c  ffffffff  f     -         0       01881
read    100c  00000000  0     sampled   0       01881
write   1010  ffffffff  f     -         1       01881
read    1010  00000000  0     deadbeaf  1       01881
write   2000  ffffffff  f     -         1       01881
read    0ff8  00000000  0     deadbeaf  1       01881
read    1000  00000000  0     1234ff81  0       01881
read    1008  00000000  0     00000008  0       01881

// ==== testbench/tb_regblk.sv ====
`timescale 1ns/10ps

module tb_regblk;

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 10;
  localparam int CYCLES_PER_OP = 40;
  localparam     GOLDEN_FILE   = "testbench/tb_regblk_golden.txt";

  logic                          clk;
  logic                          i_arst_n;
  logic                          i_psel;
  logic                          i_penable;
  regblk_pkg::addr_t             i_paddr;
  logic                          i_pwrite;
  regblk_pkg::strb_t             i_pstrb;
  regblk_pkg::data_t             i_pwdata;
  logic                          o_pready;
  regblk_pkg::data_t             o_prdata;
  logic                          o_pslverr;
  logic [3:0]                    o_ctrl_mode;
  regblk_pkg::event_t            o_irq_en;
  regblk_pkg::event_t            o_trigger;
  regblk_pkg::event_t            i_status_set;
  regblk_pkg::event_t            o_status;
  logic                          o_irq;
  logic [regblk_pkg::HW_W-1:0]   i_hw_value;

  integer                        seed;
  int                            n_ops = 0;
  int                            n_errors = 0;
  logic [regblk_pkg::HW_W-1:0]   hw_prev;
  logic [regblk_pkg::HW_W-1:0]   hw_sampled;

  regblk_top i_dut (
    .clk          (clk         ),
    .i_arst_n     (i_arst_n    ),
    .i_psel       (i_psel      ),
    .i_penable    (i_penable   ),
    .i_paddr      (i_paddr     ),
    .i_pwrite     (i_pwrite    ),
    .i_pstrb      (i_pstrb     ),
    .i_pwdata     (i_pwdata    ),
    .o_pready     (o_pready    ),
    .o_prdata     (o_prdata    ),
    .o_pslverr    (o_pslverr   ),
    .o_ctrl_mode  (o_ctrl_mode ),
    .o_irq_en     (o_irq_en    ),
    .o_trigger    (o_trigger   ),
    .i_status_set (i_status_set),
    .o_status     (o_status    ),
    .o_irq        (o_irq       ),
    .i_hw_value   (i_hw_value  )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD/2) clk = ~clk;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      n_errors++;
      $display("mismatch %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  // Falling edge, new random value on the hardware input
  task automatic next_cycle();
    logic [31:0] rnd;
    @(negedge clk);
    hw_prev    = i_hw_value;
    rnd        = $random(seed);
    i_hw_value = rnd[regblk_pkg::HW_W-1:0];
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic count_ops();
    int    fd;
    int    count;
    string op;
    count = 0;
    fd    = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open golden file %s", GOLDEN_FILE);
      abort_run();
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op != "#") begin
          count++;
        end
        skip_line(fd);
      end
      $fclose(fd);
      n_ops = count;
    end
  endtask

  // Setup cycle then access cycle, response sampled at the access edge
  task automatic apb_transfer(input logic wr, input regblk_pkg::addr_t addr,
                              input regblk_pkg::data_t wdata, input regblk_pkg::strb_t strb,
                              output regblk_pkg::data_t rdata, output logic slverr);
    next_cycle();
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_paddr   = addr;
    i_pwrite  = wr;
    i_pwdata  = wdata;
    i_pstrb   = strb;
    @(posedge clk);
    check("o_pready in setup", o_pready, 32'h0);
    next_cycle();
    hw_sampled = hw_prev;
    i_penable  = 1'b1;
    @(posedge clk);
    check("o_pready in access", o_pready, 32'h1);
    rdata  = o_prdata;
    slverr = o_pslverr;
    next_cycle();
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  // Side value packs trigger, irq, status, irq_en and mode, one hex digit each
  task automatic observe_side(input string exp_side);
    logic [31:0] side;
    @(posedge clk);
    side = {12'h0, o_trigger, 3'b000, o_irq, o_status, o_irq_en, o_ctrl_mode};
    if (exp_side != "-") begin
      check("side {trigger, irq, status, irq_en, mode}", side, exp_side.atohex());
    end
    check("o_pready when idle", o_pready, 32'h0);
    next_cycle();
    @(posedge clk);
    check("o_trigger one cycle later", o_trigger, 32'h0);
  endtask

  task automatic run_op(input string op, input regblk_pkg::addr_t addr,
                        input regblk_pkg::data_t data, input regblk_pkg::strb_t strb,
                        input string exp_rd, input string exp_err, input string exp_side);
    regblk_pkg::data_t rdata;
    regblk_pkg::data_t exp_data;
    logic              slverr;
    if (op == "write" || op == "read") begin
      apb_transfer(op == "write", addr, data, strb, rdata, slverr);
      if (exp_rd == "sampled") begin
        exp_data = '0;
        exp_data[regblk_pkg::HW_W-1:0] = hw_sampled;
        check("o_prdata", rdata, exp_data);
      end else if (exp_rd != "-") begin
        check("o_prdata", rdata, exp_rd.atohex());
      end
      if (exp_err != "-") begin
        check("o_pslverr", slverr, exp_err.atohex());
      end
      observe_side(exp_side);
    end else if (op == "set") begin
      // Level holds until the next set line
      next_cycle();
      i_status_set = data[regblk_pkg::N_EVENTS-1:0];
      @(posedge clk);
      next_cycle();
      observe_side(exp_side);
    end else if (op == "idle") begin
      repeat (data) next_cycle();
      observe_side(exp_side);
    end else begin
      $display("Unknown opcode %s in golden file", op);
      abort_run();
    end
  endtask

  // ------------------------------
  // Golden file player
  // ------------------------------
  initial begin : main
    int                fd;
    string             op;
    string             exp_rd;
    string             exp_err;
    string             exp_side;
    regblk_pkg::addr_t addr;
    regblk_pkg::data_t data;
    regblk_pkg::strb_t strb;

    seed         = 32'hd88e;
    i_arst_n     = 1'b0;
    i_psel       = 1'b0;
    i_penable    = 1'b0;
    i_paddr      = '0;
    i_pwrite     = 1'b0;
    i_pstrb      = '0;
    i_pwdata     = '0;
    i_status_set = '0;
    i_hw_value   = '0;
    hw_prev      = '0;
    hw_sampled   = '0;

    count_ops();
    repeat (RESET_CYCLES) @(negedge clk);
    i_arst_n = 1'b1;

    fd = $fopen(GOLDEN_FILE, "r");
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        skip_line(fd);
      end else if ($fscanf(fd, "%h %h %h %s %s %s", addr, data, strb,
                           exp_rd, exp_err, exp_side) != 6) begin
        $display("Golden line for opcode %s has missing fields", op);
        abort_run();
      end else begin
        run_op(op, addr, data, strb, exp_rd, exp_err, exp_side);
      end
    end
    $fclose(fd);

    if (n_errors == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run();
    end
  end

  initial begin : watchdog
    wait (n_ops > 0);
    repeat (n_ops * CYCLES_PER_OP + RESET_CYCLES) @(posedge clk);
    $display("Timeout, golden file not finished after %0d cycles",
             n_ops * CYCLES_PER_OP + RESET_CYCLES);
    abort_run();
  end

endmodule

// ==== hdl/regblk_top.sv ====
`timescale 1ns/10ps

module regblk_top #(
  parameter regblk_pkg::addr_t BASE_ADDR         = 16'h1000,
  parameter regblk_pkg::data_t DEFAULT_READ_DATA = 32'hDEAD_BEAF,
  parameter regblk_pkg::data_t CTRL_RESET        = 32'h0000_0000
) (
  input  logic                          clk,
  input  logic                          i_arst_n,

  // APB slave
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  regblk_pkg::addr_t             i_paddr,
  input  logic                          i_pwrite,
  input  regblk_pkg::strb_t             i_pstrb,
  input  regblk_pkg::data_t             i_pwdata,
  output logic                          o_pready,
  output regblk_pkg::data_t             o_prdata,
  output logic                          o_pslverr,

  // Register fields
  output logic [3:0]                    o_ctrl_mode,
  output regblk_pkg::event_t            o_irq_en,
  output regblk_pkg::event_t            o_trigger,
  input  regblk_pkg::event_t            i_status_set,
  output regblk_pkg::event_t            o_status,
  output logic                          o_irq,
  input  logic [regblk_pkg::HW_W-1:0]   i_hw_value
);

  regblk_pkg::event_t irq_en;

  regblk_bus_if ctrl_bus (
    .clk (clk)
  );

  regblk_bus_if stat_bus (
    .clk (clk)
  );

  // ------------------------------
  // APB side
  // ------------------------------
  apb_frontend #(
    .BASE_ADDR         (BASE_ADDR        ),
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA)
  ) u_apb_frontend (
    .clk       (clk      ),
    .i_arst_n  (i_arst_n ),
    .i_psel    (i_psel   ),
    .i_penable (i_penable),
    .i_paddr   (i_paddr  ),
    .i_pwrite  (i_pwrite ),
    .i_pstrb   (i_pstrb  ),
    .i_pwdata  (i_pwdata ),
    .o_pready  (o_pready ),
    .o_prdata  (o_prdata ),
    .o_pslverr (o_pslverr),
    .ctrl_bus  (ctrl_bus ),
    .stat_bus  (stat_bus )
  );

  // ------------------------------
  // Registers
  // ------------------------------
  control_regs #(
    .CTRL_RESET (CTRL_RESET)
  ) u_control_regs (
    .clk         (clk        ),
    .i_arst_n    (i_arst_n   ),
    .bus         (ctrl_bus   ),
    .o_ctrl_mode (o_ctrl_mode),
    .o_irq_en    (irq_en     ),
    .o_trigger   (o_trigger  )
  );

  status_regs u_status_regs (
    .clk          (clk         ),
    .i_arst_n     (i_arst_n    ),
    .bus          (stat_bus    ),
    .i_irq_en     (irq_en      ),
    .i_status_set (i_status_set),
    .o_status     (o_status    ),
    .o_irq        (o_irq       ),
    .i_hw_value   (i_hw_value  )
  );

  assign o_irq_en = irq_en;

endmodule

// ==== hdl/status_regs.sv ====
`timescale 1ns/10ps

module status_regs (
  input  logic                          clk,
  input  logic                          i_arst_n,
  regblk_bus_if.slave                   bus,
  input  regblk_pkg::event_t            i_irq_en,
  input  regblk_pkg::event_t            i_status_set,
  output regblk_pkg::event_t            o_status,
  output logic                          o_irq,
  input  logic [regblk_pkg::HW_W-1:0]   i_hw_value
);

  logic                        sel_status;
  logic                        sel_hw_value;
  regblk_pkg::event_t          status_clr;
  regblk_pkg::event_t          status_q;
  logic [regblk_pkg::HW_W-1:0] hw_value_q;

  // ------------------------------
  // Offset decode
  // ------------------------------
  assign sel_status   = (bus.offset == regblk_pkg::OFS_STATUS);
  assign sel_hw_value = (bus.offset == regblk_pkg::OFS_HW_VALUE);

  // HW_VALUE writes hit but change nothing
  assign bus.hit      = sel_status | sel_hw_value;

  // ------------------------------
  // STATUS, sticky bits
  // ------------------------------
  always_comb begin
    status_clr = '0;
    if (bus.req && bus.write && sel_status && bus.strb[0]) begin
      status_clr = bus.wdata[regblk_pkg::N_EVENTS-1:0];
    end
  end

  // Hardware set wins over a clear in the same cycle
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | i_status_set;
    end
  end

  assign o_status = status_q;
  assign o_irq    = |(status_q & i_irq_en);

  // ------------------------------
  // HW_VALUE, sampled every cycle
  // ------------------------------
  always_ff @(posedge clk) begin
    hw_value_q <= i_hw_value;
  end

  always_comb begin
    bus.rdata = '0;
    if (sel_status) begin
      bus.rdata[regblk_pkg::N_EVENTS-1:0] = status_q;
    end else if (sel_hw_value) begin
      bus.rdata[regblk_pkg::HW_W-1:0] = hw_value_q;
    end
  end

endmodule

// ==== hdl/control_regs.sv ====
`timescale 1ns/10ps

module control_regs #(
  parameter regblk_pkg::data_t CTRL_RESET = 32'h0000_0000
) (
  input  logic                clk,
  input  logic                i_arst_n,
  regblk_bus_if.slave         bus,
  output logic [3:0]          o_ctrl_mode,
  output regblk_pkg::event_t  o_irq_en,
  output regblk_pkg::event_t  o_trigger
);

  localparam int MODE_W = regblk_pkg::CTRL_IRQ_EN_LSB - regblk_pkg::CTRL_MODE_LSB;

  logic               sel_ctrl;
  logic               sel_trigger;
  logic               ctrl_we;
  logic               trigger_we;
  regblk_pkg::data_t  ctrl_q;
  regblk_pkg::event_t trigger_q;

  // ------------------------------
  // Offset decode
  // ------------------------------
  assign sel_ctrl    = (bus.offset == regblk_pkg::OFS_CTRL);
  assign sel_trigger = (bus.offset == regblk_pkg::OFS_TRIGGER);

  assign bus.hit     = sel_ctrl | sel_trigger;

  assign ctrl_we     = bus.req & bus.write & sel_ctrl;
  assign trigger_we  = bus.req & bus.write & sel_trigger & bus.strb[0];

  // ------------------------------
  // CTRL register
  // ------------------------------
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ctrl_q <= CTRL_RESET;
    end else if (ctrl_we) begin
      for (int i = 0; i < regblk_pkg::STRB_W; i++) begin
        if (bus.strb[i]) begin
          ctrl_q[8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  assign o_ctrl_mode = ctrl_q[regblk_pkg::CTRL_MODE_LSB +: MODE_W];
  assign o_irq_en    = ctrl_q[regblk_pkg::CTRL_IRQ_EN_LSB +: regblk_pkg::N_EVENTS];

  // ------------------------------
  // TRIGGER, write one to pulse
  // ------------------------------
  // Cleared every cycle, so each written one lasts a single cycle
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      trigger_q <= '0;
    end else if (trigger_we) begin
      trigger_q <= bus.wdata[regblk_pkg::N_EVENTS-1:0];
    end else begin
      trigger_q <= '0;
    end
  end

  assign o_trigger = trigger_q;

  // Read back, TRIGGER reads as zero
  always_comb begin
    if (sel_ctrl) begin
      bus.rdata = ctrl_q;
    end else begin
      bus.rdata = '0;
    end
  end

endmodule

// ==== hdl/apb_frontend.sv ====
`timescale 1ns/10ps

module apb_frontend #(
  parameter regblk_pkg::addr_t BASE_ADDR         = 16'h1000,
  parameter regblk_pkg::data_t DEFAULT_READ_DATA = 32'hDEAD_BEAF
) (
  input  logic                clk,
  input  logic                i_arst_n,
  input  logic                i_psel,
  input  logic                i_penable,
  input  regblk_pkg::addr_t   i_paddr,
  input  logic                i_pwrite,
  input  regblk_pkg::strb_t   i_pstrb,
  input  regblk_pkg::data_t   i_pwdata,
  output logic                o_pready,
  output regblk_pkg::data_t   o_prdata,
  output logic                o_pslverr,
  regblk_bus_if.master        ctrl_bus,
  regblk_bus_if.master        stat_bus
);

  // 4 KB window, upper address bits select the block
  localparam int WIN_W = 12;

  logic              setup_phase;
  logic              access_phase;
  logic              in_window;
  logic              miss;
  logic              err_q;
  regblk_pkg::addr_t offset;

  // ------------------------------
  // Phase and address decode
  // ------------------------------
  assign setup_phase  = i_psel & ~i_penable;
  assign access_phase = i_psel & i_penable;

  assign in_window = (i_paddr[regblk_pkg::ADDR_W-1:WIN_W]
                      == BASE_ADDR[regblk_pkg::ADDR_W-1:WIN_W]);
  assign offset    = i_paddr - BASE_ADDR;

  // ------------------------------
  // Requests toward register modules
  // ------------------------------
  assign ctrl_bus.req    = access_phase & in_window;
  assign ctrl_bus.write  = i_pwrite;
  assign ctrl_bus.offset = offset;
  assign ctrl_bus.wdata  = i_pwdata;
  assign ctrl_bus.strb   = i_pstrb;

  assign stat_bus.req    = access_phase & in_window;
  assign stat_bus.write  = i_pwrite;
  assign stat_bus.offset = offset;
  assign stat_bus.wdata  = i_pwdata;
  assign stat_bus.strb   = i_pstrb;

  // ------------------------------
  // Response
  // ------------------------------
  // Offsets decoded outside the window do not count
  assign miss = ~in_window | ~(ctrl_bus.hit | stat_bus.hit);

  // Address is stable from setup to access, so the error is known a cycle early
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      err_q <= 1'b0;
    end else if (setup_phase) begin
      err_q <= miss;
    end
  end

  always_comb begin
    if (miss) begin
      o_prdata = DEFAULT_READ_DATA;
    end else if (ctrl_bus.hit) begin
      o_prdata = ctrl_bus.rdata;
    end else begin
      o_prdata = stat_bus.rdata;
    end
  end

  // Zero wait states
  assign o_pready  = access_phase;
  assign o_pslverr = access_phase & err_q;

endmodule

// ==== hdl/regblk_bus_if.sv ====
`timescale 1ns/10ps

interface regblk_bus_if (
  input logic clk
);

  // Request side, driven by the APB frontend
  logic              req;
  logic              write;
  regblk_pkg::addr_t offset;
  regblk_pkg::data_t wdata;
  regblk_pkg::strb_t strb;

  // Response side, combinational in the register module
  logic              hit;
  regblk_pkg::data_t rdata;

  modport master (
    input  clk,
    output req,
    output write,
    output offset,
    output wdata,
    output strb,
    input  hit,
    input  rdata
  );

  modport slave (
    input  clk,
    input  req,
    input  write,
    input  offset,
    input  wdata,
    input  strb,
    output hit,
    output rdata
  );

endinterface

// ==== hdl/regblk_pkg.sv ====
package regblk_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;

  // Trigger and status bit count
  localparam int N_EVENTS = 4;

  // Read-only hardware value
  localparam int HW_W     = 16;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [STRB_W-1:0]   strb_t;
  typedef logic [N_EVENTS-1:0] event_t;

  // ------------------------------
  // Register map, byte offsets
  // ------------------------------
  localparam addr_t OFS_CTRL     = 16'h0000;
  localparam addr_t OFS_TRIGGER  = 16'h0004;
  localparam addr_t OFS_STATUS   = 16'h0008;
  localparam addr_t OFS_HW_VALUE = 16'h000C;

  // CTRL field positions
  // mode occupies the bits up to the irq-enable field
  localparam int CTRL_MODE_LSB   = 0;
  localparam int CTRL_IRQ_EN_LSB = 4;

endpackage
